// ==== duel_pkg.sv ====
`default_nettype none

package duel_pkg;

	////////////////////
	// widths with a meaning

	// field coordinate in pixels
	typedef logic [9:0] coord_t;
	// player score or round target
	typedef logic [19:0] score_t;
	// seconds left in the round
	typedef logic [5:0] seconds_t;

	////////////////////
	// encodings

	// codes 6 and 7 mark an empty slot
	typedef enum logic [2:0] {
		BIG_GOLD    = 3'd0,
		MID_GOLD    = 3'd1,
		SMALL_GOLD  = 3'd2,
		BIG_STONE   = 3'd3,
		SMALL_STONE = 3'd4,
		DIAMOND     = 3'd5
	} item_kind_e;

	typedef enum logic [1:0] {
		HOOK_IDLE = 2'd0,
		HOOK_DROP = 2'd1,
		HOOK_REEL = 2'd2
	} hook_state_e;

	////////////////////
	// motion constants, pixels per game tick
	localparam int DROP_STEP       = 4;
	localparam int REEL_STEP_LIGHT = 4;
	localparam int REEL_STEP_HEAVY = 1;
	// catch window around an object centre, per axis
	localparam int HIT_RADIUS      = 6;

	// score credited for one object
	function automatic score_t item_value(input item_kind_e kind);
		unique case (kind)
			BIG_GOLD:    return score_t'(500);
			MID_GOLD:    return score_t'(250);
			SMALL_GOLD:  return score_t'(100);
			BIG_STONE:   return score_t'(20);
			SMALL_STONE: return score_t'(11);
			DIAMOND:     return score_t'(600);
			default:     return '0;
		endcase
	endfunction

	// heavy objects reel in at the slow rate
	function automatic logic item_heavy(input item_kind_e kind);
		return (kind == BIG_GOLD) || (kind == BIG_STONE);
	endfunction

endpackage

`default_nettype wire

// ==== hook_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module hook_unit import duel_pkg::*; #(
	parameter int ANCHOR_X = 200,
	parameter int ANCHOR_Y = 40,
	parameter int FLOOR_Y  = 460,
	parameter int SWING    = 60
) (
	input  logic        Clk,
	input  logic        arst_n,
	input  logic        new_game,
	input  logic        game_tick,
	input  logic        want_catch,
	input  logic        grab,
	input  logic        heavy_load,
	output hook_state_e hook_state,
	output coord_t      tail_x,
	output coord_t      tail_y,
	output logic        reel_done
);

	// signed aim offset from the anchor column
	logic signed [10:0] offset;
	// swing direction, 1 moves right
	logic               dir_up;
	// reel speed follows the current load
	int                 reel_step;

	assign reel_step = heavy_load ? REEL_STEP_HEAVY : REEL_STEP_LIGHT;

	// column frozen while offset is frozen
	assign tail_x = coord_t'(ANCHOR_X + offset);

	////////////////////
	// hook FSM

	always_ff @(posedge Clk or negedge arst_n) begin
		if (!arst_n) begin
			hook_state <= HOOK_IDLE;
			offset     <= '0;
			dir_up     <= 1'b1;
			tail_y     <= coord_t'(ANCHOR_Y);
			reel_done  <= 1'b0;
		end else if (new_game) begin
			hook_state <= HOOK_IDLE;
			offset     <= '0;
			dir_up     <= 1'b1;
			tail_y     <= coord_t'(ANCHOR_Y);
			reel_done  <= 1'b0;
		end else begin
			// single cycle pulse
			reel_done <= 1'b0;
			if (game_tick) begin
				unique case (hook_state)
					HOOK_IDLE: begin
						if (want_catch) begin
							// launch, aim stops here
							hook_state <= HOOK_DROP;
						end else if (dir_up) begin
							if (offset >= SWING) begin
								dir_up <= 1'b0;
								offset <= offset - 11'sd1;
							end else begin
								offset <= offset + 11'sd1;
							end
						end else begin
							if (offset <= -SWING) begin
								dir_up <= 1'b1;
								offset <= offset + 11'sd1;
							end else begin
								offset <= offset - 11'sd1;
							end
						end
					end
					HOOK_DROP: begin
						if (grab) begin
							// caught, start back at this depth
							hook_state <= HOOK_REEL;
						end else if (tail_y + DROP_STEP >= FLOOR_Y) begin
							// bottom of the field
							tail_y     <= coord_t'(FLOOR_Y);
							hook_state <= HOOK_REEL;
						end else begin
							tail_y <= coord_t'(tail_y + DROP_STEP);
						end
					end
					HOOK_REEL: begin
						if (tail_y <= ANCHOR_Y + reel_step) begin
							// home, clamp to the anchor
							tail_y     <= coord_t'(ANCHOR_Y);
							hook_state <= HOOK_IDLE;
							reel_done  <= 1'b1;
						end else begin
							tail_y <= coord_t'(tail_y - reel_step);
						end
					end
					default: hook_state <= HOOK_IDLE;
				endcase
			end
		end
	end

	// tail stays between anchor and floor
	a_tail_range: assert property (@(posedge Clk) disable iff (!arst_n)
		(tail_y >= ANCHOR_Y) && (tail_y <= FLOOR_Y));

endmodule

`default_nettype wire

// ==== item_slot.sv ====
`timescale 1ns/10ps
`default_nettype none

module item_slot import duel_pkg::*; (
	input  logic        Clk,
	input  logic        arst_n,
	input  logic        new_game,
	input  logic        game_tick,
	input  coord_t      item_x,
	input  coord_t      item_y,
	input  item_kind_e  kind,
	input  hook_state_e state_l,
	input  hook_state_e state_r,
	input  coord_t      tail_xl,
	input  coord_t      tail_yl,
	input  coord_t      tail_xr,
	input  coord_t      tail_yr,
	input  logic        reel_done_l,
	input  logic        reel_done_r,
	output logic        grab_l,
	output logic        grab_r,
	output logic        held_l,
	output logic        held_r,
	output logic        gone
);

	// position latched at round start
	coord_t pos_x;
	coord_t pos_y;
	logic   on_field;
	logic   hit_l;
	logic   hit_r;

	function automatic logic near(input coord_t a, input coord_t b);
		coord_t d;
		d = (a > b) ? (a - b) : (b - a);
		return d <= HIT_RADIUS;
	endfunction

	always_ff @(posedge Clk) begin
		if (new_game) begin
			pos_x <= item_x;
			pos_y <= item_y;
		end
	end

	assign on_field = !gone && !held_l && !held_r;

	// only a dropping tail can catch
	assign hit_l = on_field && (state_l == HOOK_DROP) &&
		near(tail_xl, pos_x) && near(tail_yl, pos_y);
	assign hit_r = on_field && (state_r == HOOK_DROP) &&
		near(tail_xr, pos_x) && near(tail_yr, pos_y);

	// left hook wins a tie
	assign grab_l = game_tick && hit_l;
	assign grab_r = game_tick && hit_r && !hit_l;

	////////////////////
	// field, held, gone

	always_ff @(posedge Clk or negedge arst_n) begin
		if (!arst_n) begin
			// field empty until the first round
			gone   <= 1'b1;
			held_l <= 1'b0;
			held_r <= 1'b0;
		end else if (new_game) begin
			// empty slot codes start out gone
			gone   <= (kind > DIAMOND);
			held_l <= 1'b0;
			held_r <= 1'b0;
		end else begin
			if (grab_l) begin
				held_l <= 1'b1;
			end else if (grab_r) begin
				held_r <= 1'b1;
			end
			// holder is home, object leaves
			if (held_l && reel_done_l) begin
				held_l <= 1'b0;
				gone   <= 1'b1;
			end
			if (held_r && reel_done_r) begin
				held_r <= 1'b0;
				gone   <= 1'b1;
			end
		end
	end

	// one owner at a time
	a_single_owner: assert property (@(posedge Clk) disable iff (!arst_n)
		!(held_l && held_r));

endmodule

`default_nettype wire

// ==== item_field.sv ====
`timescale 1ns/10ps
`default_nettype none

module item_field import duel_pkg::*; #(
	parameter int NUM_ITEMS = 8
) (
	input  logic             Clk,
	input  logic             arst_n,
	input  logic             new_game,
	input  logic             game_tick,
	input  coord_t           item_x [NUM_ITEMS],
	input  coord_t           item_y [NUM_ITEMS],
	input  item_kind_e       kinds [NUM_ITEMS],
	input  hook_state_e      state_l,
	input  hook_state_e      state_r,
	input  coord_t           tail_xl,
	input  coord_t           tail_yl,
	input  coord_t           tail_xr,
	input  coord_t           tail_yr,
	input  logic             reel_done_l,
	input  logic             reel_done_r,
	output logic             grab_l,
	output logic             grab_r,
	output logic             heavy_load_l,
	output logic             heavy_load_r,
	output logic             collect_l,
	output logic             collect_r,
	output score_t           collect_value_l,
	output score_t           collect_value_r,
	output logic [NUM_ITEMS-1:0] gone_mask
);

	logic [NUM_ITEMS-1:0] grab_vl;
	logic [NUM_ITEMS-1:0] grab_vr;
	logic [NUM_ITEMS-1:0] held_vl;
	logic [NUM_ITEMS-1:0] held_vr;
	logic [NUM_ITEMS-1:0] heavy_v;
	// kinds latched with the positions
	item_kind_e           kind_q [NUM_ITEMS];
	score_t               sum_l;
	score_t               sum_r;

	for (genvar i = 0; i < NUM_ITEMS; i++) begin : g_slot
		item_slot u_slot (
			.Clk         (Clk),
			.arst_n      (arst_n),
			.new_game    (new_game),
			.game_tick   (game_tick),
			.item_x      (item_x[i]),
			.item_y      (item_y[i]),
			.kind        (kinds[i]),
			.state_l     (state_l),
			.state_r     (state_r),
			.tail_xl     (tail_xl),
			.tail_yl     (tail_yl),
			.tail_xr     (tail_xr),
			.tail_yr     (tail_yr),
			.reel_done_l (reel_done_l),
			.reel_done_r (reel_done_r),
			.grab_l      (grab_vl[i]),
			.grab_r      (grab_vr[i]),
			.held_l      (held_vl[i]),
			.held_r      (held_vr[i]),
			.gone        (gone_mask[i])
		);
	end

	always_ff @(posedge Clk) begin
		if (new_game) begin
			kind_q <= kinds;
		end
	end

	////////////////////
	// per player reductions

	always_comb begin
		sum_l = '0;
		sum_r = '0;
		for (int i = 0; i < NUM_ITEMS; i++) begin
			heavy_v[i] = item_heavy(kind_q[i]);
			// a hook may carry more than one object
			if (held_vl[i]) begin
				sum_l = sum_l + item_value(kind_q[i]);
			end
			if (held_vr[i]) begin
				sum_r = sum_r + item_value(kind_q[i]);
			end
		end
	end

	assign grab_l       = |grab_vl;
	assign grab_r       = |grab_vr;
	assign heavy_load_l = |(held_vl & heavy_v);
	assign heavy_load_r = |(held_vr & heavy_v);

	// collect one cycle after reel_done, empty hook gives nothing
	always_ff @(posedge Clk or negedge arst_n) begin
		if (!arst_n) begin
			collect_l <= 1'b0;
			collect_r <= 1'b0;
		end else if (new_game) begin
			collect_l <= 1'b0;
			collect_r <= 1'b0;
		end else begin
			collect_l <= reel_done_l && (|held_vl);
			collect_r <= reel_done_r && (|held_vr);
		end
	end

	// value travels with the pulse
	always_ff @(posedge Clk) begin
		collect_value_l <= sum_l;
		collect_value_r <= sum_r;
	end

endmodule

`default_nettype wire

// ==== round_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module round_timer import duel_pkg::*; #(
	parameter int TICKS_PER_SECOND = 60,
	parameter int ROUND_SECONDS    = 60
) (
	input  logic     Clk,
	input  logic     arst_n,
	input  logic     new_game,
	input  logic     game_tick,
	output seconds_t seconds,
	output logic     time_end
);

	localparam int PW = (TICKS_PER_SECOND > 1) ? $clog2(TICKS_PER_SECOND) : 1;

	// ticks within the current second
	logic [PW-1:0] presc;

	////////////////////
	// countdown

	always_ff @(posedge Clk or negedge arst_n) begin
		if (!arst_n) begin
			presc    <= '0;
			seconds  <= '0;
			time_end <= 1'b0;
		end else if (new_game) begin
			presc    <= '0;
			seconds  <= seconds_t'(ROUND_SECONDS);
			time_end <= 1'b0;
		end else if (game_tick && (seconds != '0)) begin
			// zero seconds means no round running
			if (presc == PW'(TICKS_PER_SECOND - 1)) begin
				presc   <= '0;
				seconds <= seconds - seconds_t'(1);
				// last second gone
				if (seconds == seconds_t'(1)) begin
					time_end <= 1'b1;
				end
			end else begin
				presc <= presc + PW'(1);
			end
		end
	end

	a_seconds_max: assert property (@(posedge Clk) disable iff (!arst_n)
		seconds <= ROUND_SECONDS);

endmodule

`default_nettype wire

// ==== score_keeper.sv ====
`timescale 1ns/10ps
`default_nettype none

module score_keeper import duel_pkg::*; (
	input  logic   Clk,
	input  logic   arst_n,
	input  logic   new_game,
	input  logic   collect_l,
	input  logic   collect_r,
	input  logic   time_end,
	input  score_t collect_value_l,
	input  score_t collect_value_r,
	input  score_t target_score,
	output score_t score_l,
	output score_t score_r,
	output score_t total_score,
	output logic   show_fail
);

	// previous time_end for edge detect
	logic time_end_q;

	assign total_score = score_l + score_r;

	////////////////////
	// accumulate and judge

	always_ff @(posedge Clk or negedge arst_n) begin
		if (!arst_n) begin
			score_l    <= '0;
			score_r    <= '0;
			time_end_q <= 1'b0;
			show_fail  <= 1'b0;
		end else if (new_game) begin
			score_l    <= '0;
			score_r    <= '0;
			time_end_q <= 1'b0;
			show_fail  <= 1'b0;
		end else begin
			time_end_q <= time_end;
			// scores frozen once time is up
			if (!time_end) begin
				if (collect_l) begin
					score_l <= score_l + collect_value_l;
				end
				if (collect_r) begin
					score_r <= score_r + collect_value_r;
				end
			end
			// verdict on the round end edge
			if (time_end && !time_end_q) begin
				show_fail <= (total_score < target_score);
			end
		end
	end

endmodule

`default_nettype wire

// ==== duel_game_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module duel_game_top import duel_pkg::*; #(
	parameter int NUM_ITEMS        = 8,
	parameter int TICKS_PER_SECOND = 60,
	parameter int ROUND_SECONDS    = 60
) (
	input  logic                 Clk,
	input  logic                 arst_n,
	input  logic                 new_game,
	input  logic                 game_tick,
	input  logic                 want_catch_l,
	input  logic                 want_catch_r,
	input  score_t               target_score,
	input  coord_t               item_x [NUM_ITEMS],
	input  coord_t               item_y [NUM_ITEMS],
	input  item_kind_e           kinds [NUM_ITEMS],
	output hook_state_e          hook_state_l,
	output hook_state_e          hook_state_r,
	output coord_t               tail_xl,
	output coord_t               tail_yl,
	output coord_t               tail_xr,
	output coord_t               tail_yr,
	output logic [NUM_ITEMS-1:0] gone_mask,
	output score_t               score_l,
	output score_t               score_r,
	output score_t               total_score,
	output seconds_t             seconds,
	output logic                 time_end,
	output logic                 show_fail
);

	// hook geometry
	localparam int ANCHOR_XL = 200;
	localparam int ANCHOR_XR = 440;
	localparam int ANCHOR_Y  = 40;
	localparam int FLOOR_Y   = 460;
	localparam int SWING     = 60;

	logic   grab_l;
	logic   grab_r;
	logic   heavy_load_l;
	logic   heavy_load_r;
	logic   reel_done_l;
	logic   reel_done_r;
	logic   collect_l;
	logic   collect_r;
	score_t collect_value_l;
	score_t collect_value_r;

	////////////////////
	// hooks

	hook_unit #(
		.ANCHOR_X (ANCHOR_XL),
		.ANCHOR_Y (ANCHOR_Y),
		.FLOOR_Y  (FLOOR_Y),
		.SWING    (SWING)
	) u_hook_l (
		.Clk        (Clk),
		.arst_n     (arst_n),
		.new_game   (new_game),
		.game_tick  (game_tick),
		.want_catch (want_catch_l),
		.grab       (grab_l),
		.heavy_load (heavy_load_l),
		.hook_state (hook_state_l),
		.tail_x     (tail_xl),
		.tail_y     (tail_yl),
		.reel_done  (reel_done_l)
	);

	hook_unit #(
		.ANCHOR_X (ANCHOR_XR),
		.ANCHOR_Y (ANCHOR_Y),
		.FLOOR_Y  (FLOOR_Y),
		.SWING    (SWING)
	) u_hook_r (
		.Clk        (Clk),
		.arst_n     (arst_n),
		.new_game   (new_game),
		.game_tick  (game_tick),
		.want_catch (want_catch_r),
		.grab       (grab_r),
		.heavy_load (heavy_load_r),
		.hook_state (hook_state_r),
		.tail_x     (tail_xr),
		.tail_y     (tail_yr),
		.reel_done  (reel_done_r)
	);

	////////////////////
	// field, timer, scores

	item_field #(
		.NUM_ITEMS (NUM_ITEMS)
	) u_field (
		.Clk             (Clk),
		.arst_n          (arst_n),
		.new_game        (new_game),
		.game_tick       (game_tick),
		.item_x          (item_x),
		.item_y          (item_y),
		.kinds           (kinds),
		.state_l         (hook_state_l),
		.state_r         (hook_state_r),
		.tail_xl         (tail_xl),
		.tail_yl         (tail_yl),
		.tail_xr         (tail_xr),
		.tail_yr         (tail_yr),
		.reel_done_l     (reel_done_l),
		.reel_done_r     (reel_done_r),
		.grab_l          (grab_l),
		.grab_r          (grab_r),
		.heavy_load_l    (heavy_load_l),
		.heavy_load_r    (heavy_load_r),
		.collect_l       (collect_l),
		.collect_r       (collect_r),
		.collect_value_l (collect_value_l),
		.collect_value_r (collect_value_r),
		.gone_mask       (gone_mask)
	);

	round_timer #(
		.TICKS_PER_SECOND (TICKS_PER_SECOND),
		.ROUND_SECONDS    (ROUND_SECONDS)
	) u_timer (
		.Clk       (Clk),
		.arst_n    (arst_n),
		.new_game  (new_game),
		.game_tick (game_tick),
		.seconds   (seconds),
		.time_end  (time_end)
	);

	score_keeper u_scores (
		.Clk             (Clk),
		.arst_n          (arst_n),
		.new_game        (new_game),
		.collect_l       (collect_l),
		.collect_r       (collect_r),
		.time_end        (time_end),
		.collect_value_l (collect_value_l),
		.collect_value_r (collect_value_r),
		.target_score    (target_score),
		.score_l         (score_l),
		.score_r         (score_r),
		.total_score     (total_score),
		.show_fail       (show_fail)
	);

endmodule

`default_nettype wire

// ==== tb_duel_game.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_duel_game import duel_pkg::*; ();

	// short rounds for simulation
	localparam int N_ITEMS     = 8;
	localparam int TPS         = 4;
	localparam int ROUND_S     = 8;
	// hook geometry of the top level
	localparam int ANCHOR_XL   = 200;
	localparam int ANCHOR_XR   = 440;
	localparam int ANCHOR_Y    = 40;
	localparam int FLOOR_Y     = 460;
	localparam int SWING       = 60;
	// right hook launch tick in the round end test, after time_end
	localparam int LATE_LAUNCH = 34;
	localparam int TARGET      = 400;

	logic                 Clk;
	logic                 arst_n;
	logic                 new_game;
	logic                 game_tick;
	logic                 want_catch_l;
	logic                 want_catch_r;
	score_t               target_score;
	coord_t               item_x [N_ITEMS];
	coord_t               item_y [N_ITEMS];
	item_kind_e           kinds [N_ITEMS];
	hook_state_e          hook_state_l;
	hook_state_e          hook_state_r;
	coord_t               tail_xl;
	coord_t               tail_yl;
	coord_t               tail_xr;
	coord_t               tail_yr;
	logic [N_ITEMS-1:0]   gone_mask;
	score_t               score_l;
	score_t               score_r;
	score_t               total_score;
	seconds_t             seconds;
	logic                 time_end;
	logic                 show_fail;

	int                   errors;
	int                   timeouts;
	// tick edges seen since the last new_game
	int                   ticks;
	int                   cyc_cnt;
	int unsigned          lcg_state;
	// expected scores and field
	int                   exp_l;
	int                   exp_r;
	logic [N_ITEMS-1:0]   exp_gone;

	duel_game_top #(
		.NUM_ITEMS        (N_ITEMS),
		.TICKS_PER_SECOND (TPS),
		.ROUND_SECONDS    (ROUND_S)
	) dut (
		.Clk          (Clk),
		.arst_n       (arst_n),
		.new_game     (new_game),
		.game_tick    (game_tick),
		.want_catch_l (want_catch_l),
		.want_catch_r (want_catch_r),
		.target_score (target_score),
		.item_x       (item_x),
		.item_y       (item_y),
		.kinds        (kinds),
		.hook_state_l (hook_state_l),
		.hook_state_r (hook_state_r),
		.tail_xl      (tail_xl),
		.tail_yl      (tail_yl),
		.tail_xr      (tail_xr),
		.tail_yr      (tail_yr),
		.gone_mask    (gone_mask),
		.score_l      (score_l),
		.score_r      (score_r),
		.total_score  (total_score),
		.seconds      (seconds),
		.time_end     (time_end),
		.show_fail    (show_fail)
	);

	always #50 Clk = ~Clk;

	// frame strobe, one cycle in four
	always @(posedge Clk) begin
		#10;
		if (!arst_n) begin
			cyc_cnt   = 0;
			game_tick = 1'b0;
		end else begin
			cyc_cnt   = (cyc_cnt + 1) % 4;
			game_tick = (cyc_cnt == 3);
		end
	end

	////////////////////
	// reference model

	function automatic int unsigned rand_below(input int unsigned range);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return (lcg_state >> 16) % range;
	endfunction

	function automatic int absdiff(input int a, input int b);
		return (a > b) ? (a - b) : (b - a);
	endfunction

	// aim offset after n idle ticks from a fresh round
	// triangle wave of one step per tick, turns at plus and minus SWING
	function automatic int swing_offset(input int n);
		int p;
		p = n % (4 * SWING);
		if (p <= SWING) begin
			return p;
		end else if (p <= 3 * SWING) begin
			return 2 * SWING - p;
		end
		return p - 4 * SWING;
	endfunction

	function automatic int expected_value(input item_kind_e kind);
		case (kind)
			BIG_GOLD:    return 500;
			MID_GOLD:    return 250;
			SMALL_GOLD:  return 100;
			BIG_STONE:   return 20;
			SMALL_STONE: return 11;
			DIAMOND:     return 600;
			default:     return 0;
		endcase
	endfunction

	function automatic bit expected_heavy(input item_kind_e kind);
		return (kind == BIG_GOLD) || (kind == BIG_STONE);
	endfunction

	// depth where a drop over this object stops, floor if never close
	function automatic int catch_depth(input int y);
		int t;
		t = ANCHOR_Y;
		while (absdiff(t, y) > HIT_RADIUS) begin
			if (t + DROP_STEP >= FLOOR_Y) begin
				return FLOOR_Y;
			end
			t = t + DROP_STEP;
		end
		return t;
	endfunction

	// shallowest object along a drop column, -1 for none
	function automatic int predict_hit(input int lx);
		int best;
		int best_d;
		int d;
		best   = -1;
		best_d = FLOOR_Y;
		for (int i = 0; i < N_ITEMS; i++) begin
			if (absdiff(int'(item_x[i]), lx) <= HIT_RADIUS) begin
				d = catch_depth(int'(item_y[i]));
				if (d < best_d) begin
					best   = i;
					best_d = d;
				end
			end
		end
		return best;
	endfunction

	// ticks in reel, the clamping tick included
	function automatic int reel_ticks(input int depth, input bit heavy);
		int step;
		int t;
		int n;
		step = heavy ? REEL_STEP_HEAVY : REEL_STEP_LIGHT;
		t    = depth;
		n    = 1;
		while (t > ANCHOR_Y + step) begin
			t = t - step;
			n = n + 1;
		end
		return n;
	endfunction

	function automatic hook_state_e state_of(input bit left);
		return left ? hook_state_l : hook_state_r;
	endfunction

	function automatic int tail_y_of(input bit left);
		return left ? int'(tail_yl) : int'(tail_yr);
	endfunction

	////////////////////
	// reporting

	task automatic report_mismatch(input string what, input int got, input int want);
		$display("error at %0t: %s is %0d, expected %0d", $time, what, got, want);
		errors++;
	endtask

	task automatic report_timeout(input string what);
		$display("timed out at %0t waiting for %s", $time, what);
		timeouts++;
	endtask

	task automatic check_scores();
		if (score_l != score_t'(exp_l)) report_mismatch("score_l", score_l, exp_l);
		if (score_r != score_t'(exp_r)) report_mismatch("score_r", score_r, exp_r);
		if (total_score != score_t'(exp_l + exp_r)) begin
			report_mismatch("total_score", total_score, exp_l + exp_r);
		end
	endtask

	////////////////////
	// stimulus

	// returns 10 ns after the next tick edge
	task automatic next_tick();
		int n;
		n = 0;
		@(posedge Clk);
		while (!game_tick && n < 8) begin
			@(posedge Clk);
			n++;
		end
		if (!game_tick) report_timeout("game_tick");
		ticks++;
		#10;
	endtask

	task automatic settle(input int n);
		repeat (n) @(posedge Clk);
		#10;
	endtask

	task automatic advance_to(input int k);
		while (ticks < k) begin
			next_tick();
		end
	endtask

	// every object off both swing ranges
	task automatic scatter_items();
		for (int i = 0; i < N_ITEMS; i++) begin
			item_x[i] = coord_t'(560 + 56 * i + rand_below(20));
			item_y[i] = coord_t'(100 + rand_below(300));
			kinds[i]  = item_kind_e'(rand_below(6));
		end
	endtask

	task automatic put_target(input int idx, input item_kind_e kind, input int lx, input int y);
		item_x[idx] = coord_t'(lx + int'(rand_below(7)) - 3);
		item_y[idx] = coord_t'(y);
		kinds[idx]  = kind;
	endtask

	// new_game lands on the cycle after a tick
	task automatic start_round();
		next_tick();
		new_game = 1'b1;
		@(posedge Clk);
		#10;
		new_game = 1'b0;
		ticks    = 0;
		exp_l    = 0;
		exp_r    = 0;
		exp_gone = '0;
	endtask

	// both hooks still idle since new_game
	task automatic launch(input bit left, input bit right);
		int xl;
		int xr;
		xl = ANCHOR_XL + swing_offset(ticks);
		xr = ANCHOR_XR + swing_offset(ticks);
		want_catch_l = left;
		want_catch_r = right;
		next_tick();
		want_catch_l = 1'b0;
		want_catch_r = 1'b0;
		if (left && hook_state_l != HOOK_DROP) begin
			report_mismatch("left state", hook_state_l, HOOK_DROP);
		end
		if (left && tail_xl != xl) report_mismatch("tail_xl", tail_xl, xl);
		if (right && hook_state_r != HOOK_DROP) begin
			report_mismatch("right state", hook_state_r, HOOK_DROP);
		end
		if (right && tail_xr != xr) report_mismatch("tail_xr", tail_xr, xr);
	endtask

	// depth at the grab tick, then ticks until idle
	task automatic follow_catch(input bit left, output int depth, output int n);
		int guard;
		guard = 0;
		while (state_of(left) != HOOK_REEL && guard < 200) begin
			next_tick();
			guard++;
		end
		if (state_of(left) != HOOK_REEL) report_timeout("the hook to start reeling");
		depth = tail_y_of(left);
		n     = 0;
		while (state_of(left) != HOOK_IDLE && n < 600) begin
			next_tick();
			n++;
		end
		if (state_of(left) != HOOK_IDLE) report_timeout("the hook to return idle");
	endtask

	task automatic verify_catch(input bit left, input int hit, input int depth, input int n);
		int  want_depth;
		int  want_n;
		bit  heavy;
		heavy      = 1'b0;
		want_depth = FLOOR_Y;
		if (hit >= 0) begin
			want_depth = catch_depth(int'(item_y[hit]));
			heavy      = expected_heavy(kinds[hit]);
		end
		if (depth != want_depth) report_mismatch("catch depth", depth, want_depth);
		want_n = reel_ticks(want_depth, heavy);
		if (n != want_n) report_mismatch("reel ticks", n, want_n);
		if (hit >= 0) begin
			exp_gone[hit] = 1'b1;
			// reel_done on or after the round end tick is not scored
			if (ticks < TPS * ROUND_S) begin
				if (left) begin
					exp_l = exp_l + expected_value(kinds[hit]);
				end else begin
					exp_r = exp_r + expected_value(kinds[hit]);
				end
			end
		end
		if (gone_mask != exp_gone) report_mismatch("gone_mask", gone_mask, exp_gone);
		check_scores();
	endtask

	// collect then score, two cycles after idle
	task automatic run_catch(input bit left, output int n);
		int hit;
		int depth;
		hit = predict_hit((left ? ANCHOR_XL : ANCHOR_XR) + swing_offset(ticks));
		launch(left, !left);
		follow_catch(left, depth, n);
		settle(2);
		verify_catch(left, hit, depth, n);
	endtask

	////////////////////
	// main sequence

	initial begin
		int n;
		int n_heavy;
		int n_light;
		int k;
		int idx;
		int idx_r;
		int lx;
		int hit_l;
		int hit_r;
		int depth;
		int guard;

		Clk          = 1'b0;
		arst_n       = 1'b0;
		new_game     = 1'b0;
		game_tick    = 1'b0;
		want_catch_l = 1'b0;
		want_catch_r = 1'b0;
		target_score = score_t'(TARGET);
		errors       = 0;
		timeouts     = 0;
		ticks        = 0;
		cyc_cnt      = 0;
		exp_l        = 0;
		exp_r        = 0;
		exp_gone     = '0;
		lcg_state    = 30022;
		scatter_items();

		repeat (2) @(posedge Clk);
		#10;
		arst_n = 1'b1;

		// idle and cleared until the first new_game
		if (hook_state_l != HOOK_IDLE) begin
			report_mismatch("left state", hook_state_l, HOOK_IDLE);
		end
		if (hook_state_r != HOOK_IDLE) begin
			report_mismatch("right state", hook_state_r, HOOK_IDLE);
		end
		check_scores();
		if (seconds != '0) report_mismatch("seconds", seconds, 0);
		if (time_end) report_mismatch("time_end", time_end, 0);
		if (show_fail) report_mismatch("show_fail", show_fail, 0);

		// empty column, down to the floor and back
		start_round();
		advance_to(rand_below(8));
		run_catch(1'b1, n);

		// one object of each kind, players alternate
		for (int kd = 0; kd < 6; kd++) begin
			k   = rand_below(8);
			idx = rand_below(N_ITEMS);
			lx  = ((kd % 2 == 0) ? ANCHOR_XL : ANCHOR_XR) + swing_offset(k);
			scatter_items();
			put_target(idx, item_kind_e'(kd), lx, 48 + rand_below(13));
			start_round();
			advance_to(k);
			run_catch(kd % 2 == 0, n);
		end

		// same depth, heavy against light
		scatter_items();
		put_target(3, BIG_GOLD, ANCHOR_XL + swing_offset(5), 60);
		start_round();
		advance_to(5);
		run_catch(1'b1, n_heavy);
		put_target(3, SMALL_GOLD, ANCHOR_XL + swing_offset(5), 60);
		start_round();
		advance_to(5);
		run_catch(1'b1, n_light);
		if (n_heavy <= n_light) report_mismatch("heavy reel ticks", n_heavy, n_light + 1);

		// both launch together, anchors too far apart for the right tail to reach
		k   = rand_below(8);
		idx = rand_below(N_ITEMS);
		scatter_items();
		put_target(idx, item_kind_e'(rand_below(6)), ANCHOR_XL + swing_offset(k),
			48 + rand_below(13));
		start_round();
		advance_to(k);
		hit_l = predict_hit(ANCHOR_XL + swing_offset(ticks));
		hit_r = predict_hit(ANCHOR_XR + swing_offset(ticks));
		launch(1'b1, 1'b1);
		follow_catch(1'b1, depth, n);
		settle(2);
		verify_catch(1'b1, hit_l, depth, n);
		follow_catch(1'b0, depth, n);
		settle(2);
		verify_catch(1'b0, hit_r, depth, n);

		////////////////////
		// round end

		k     = rand_below(8);
		idx   = rand_below(N_ITEMS);
		idx_r = (idx + 1 + rand_below(N_ITEMS - 1)) % N_ITEMS;
		scatter_items();
		put_target(idx, item_kind_e'(rand_below(6)), ANCHOR_XL + swing_offset(k),
			48 + rand_below(13));
		put_target(idx_r, item_kind_e'(rand_below(6)), ANCHOR_XR + swing_offset(LATE_LAUNCH),
			48 + rand_below(13));
		start_round();
		advance_to(k);
		run_catch(1'b1, n);
		guard = 0;
		while (!time_end && guard < 64) begin
			next_tick();
			guard++;
		end
		if (!time_end) report_timeout("time_end");
		if (ticks != TPS * ROUND_S) begin
			report_mismatch("round length in ticks", ticks, TPS * ROUND_S);
		end
		if (seconds != '0) report_mismatch("seconds", seconds, 0);
		// verdict one cycle after the edge
		settle(1);
		if (show_fail != ((exp_l + exp_r) < TARGET)) begin
			report_mismatch("show_fail", show_fail, (exp_l + exp_r) < TARGET);
		end
		advance_to(LATE_LAUNCH);
		run_catch(1'b0, n);
		if (show_fail != ((exp_l + exp_r) < TARGET)) begin
			report_mismatch("show_fail", show_fail, (exp_l + exp_r) < TARGET);
		end

		// fresh round clears the field and scores
		start_round();
		if (gone_mask != '0) report_mismatch("gone_mask", gone_mask, 0);
		check_scores();
		if (seconds != seconds_t'(ROUND_S)) report_mismatch("seconds", seconds, ROUND_S);
		if (time_end) report_mismatch("time_end", time_end, 0);
		if (show_fail) report_mismatch("show_fail", show_fail, 0);

		$display("%0d value errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
duel_pkg.sv
hook_unit.sv
item_slot.sv
item_field.sv
round_timer.sv
score_keeper.sv
duel_game_top.sv
tb_duel_game.sv

// ==== Bender.yml ====
package:
  name: duel_game

sources:
  - duel_pkg.sv
  - hook_unit.sv
  - item_slot.sv
  - item_field.sv
  - round_timer.sv
  - score_keeper.sv
  - duel_game_top.sv
  - target: simulation
    files:
      - tb_duel_game.sv
